//--- list.f
common/video_timing_pkg.sv
common/pixel_pkg.sv
hdl/sync_gen.sv
playfield/playfield_shifter.sv
playfield/color_ram.sv
hdl/video_out.sv
hdl/centipede_video.sv
tb/centipede_video_chk.sv
tb/tb_centipede_video.sv

//--- tb/tb_centipede_video.sv
/*
 * Testbench for centipede_video.
 * Each table entry runs for one whole frame: colors are written in vblank,
 * then every row request of the frame is answered with the entry's row.
 * Expected pixels come from the bitplane and palette rules and are checked
 * in order on every visible cycle of sync_o.
 */
module tb_centipede_video;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_TESTS = 6;
   localparam int FRAME_CYCLES = video_timing_pkg::H_TOTAL * video_timing_pkg::V_TOTAL;
   localparam int ROWS_PER_FRAME = video_timing_pkg::V_VISIBLE *
                                   video_timing_pkg::H_VISIBLE / video_timing_pkg::ROW_PIXELS;
   // each test takes about one frame, three per test leaves room for lead-in and finish
   localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES * N_TESTS;

   // color entry for pixel code c sits in colors[4c+3:4c]
   typedef struct packed {
      logic [15:0]          colors;
      pixel_pkg::tile_row_t row;
   } test_vec_t;

   logic                 s_6mhz;
   logic                 reset;
   pixel_pkg::color_wr_t color_wr_i;
   pixel_pkg::tile_row_t tile_row_i;
   logic                 row_req_o;
   pixel_pkg::rgb9_t     rgb_o;
   pixel_pkg::sync_t     sync_o;

   test_vec_t        tests [N_TESTS];
   pixel_pkg::rgb9_t exp_q [$];
   integer           seed;
   logic [31:0]      rnd;
   logic             mon_active;
   int               timeout_count;
   int               vs_checks;

   centipede_video uut (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .color_wr_i (color_wr_i),
      .tile_row_i (tile_row_i),
      .row_req_o  (row_req_o),
      .rgb_o      (rgb_o),
      .sync_o     (sync_o)
   );

   bind centipede_video centipede_video_chk u_chk (
      .s_6mhz    (s_6mhz),
      .reset     (reset),
      .row_req_i (row_req_o),
      .rgb_i     (rgb_o),
      .sync_i    (sync_o)
   );

   // 20 ns pixel clock
   initial s_6mhz = 1'b0;
   always #10 s_6mhz = ~s_6mhz;

   task automatic report_fail(input string what);
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
         else report_fail($sformatf("error: %s expected 0x%0h got 0x%0h", name, exp, got));
   endtask

   // model: code {plane1, plane0}, msb first unless mirrored
   task automatic push_pixels(input pixel_pkg::tile_row_t row, input logic [15:0] colors);
      int               idx;
      logic [1:0]       code;
      pixel_pkg::rgbi_t entry;
      for (int k = 0; k < video_timing_pkg::ROW_PIXELS; k++)
      begin
         idx = row.mirror ? k : video_timing_pkg::ROW_PIXELS - 1 - k;
         code = {row.plane1[idx], row.plane0[idx]};
         entry = colors[int'(code) * 4 +: 4];
         exp_q.push_back(pixel_pkg::PALETTE[entry]);
      end
   endtask

   // keeps junk on the row input until sync_o enters vblank
   task automatic wait_vblank();
      do
      begin
         @(negedge s_6mhz);
         rnd = $random(seed);
         tile_row_i = rnd[16:0];
      end while (!sync_o.vblank);
   endtask

   // four playfield entries, one write per cycle
   task automatic write_colors(input logic [15:0] colors);
      for (int i = 0; i < 4; i++)
      begin
         color_wr_i.we = 1'b1;
         color_wr_i.addr = pixel_pkg::PF_COLOR_BASE + 4'(i);
         color_wr_i.data = colors[i*4 +: 4];
         @(negedge s_6mhz);
      end
      color_wr_i = '0;
   endtask

   // answer each request of one frame, junk in between
   task automatic serve_frame(input test_vec_t tv);
      int served;
      served = 0;
      while (served < ROWS_PER_FRAME)
      begin
         @(negedge s_6mhz);
         if (row_req_o)
         begin
            tile_row_i = tv.row;
            push_pixels(tv.row, tv.colors);
            served++;
         end
         else
         begin
            rnd = $random(seed);
            tile_row_i = rnd[16:0];
         end
      end
   endtask

   task automatic check_idle_outputs();
      check_hex("rgb_o", rgb_o, 0);
      check_hex("sync_o", sync_o, 0);
      check_hex("row_req_o", row_req_o, 0);
   endtask

   initial
   begin
      reset = 1'b1;
      color_wr_i = '0;
      tile_row_i = '0;
      mon_active = 1'b0;
      seed = 50;
      // fixed rows, test 1 mirrored
      tests[0] = '{colors: 16'h4210, row: '{plane1: 8'hF0, plane0: 8'hCC, mirror: 1'b0}};
      tests[1] = '{colors: 16'hCA98, row: '{plane1: 8'h1E, plane0: 8'h36, mirror: 1'b1}};
      tests[2] = '{colors: 16'hD653, row: '{plane1: 8'h81, plane0: 8'h7E, mirror: 1'b0}};
      for (int t = 3; t < N_TESTS; t++)
      begin
         rnd = $random(seed);
         tests[t].colors = rnd[15:0];
         rnd = $random(seed);
         tests[t].row = rnd[16:0];
      end
      repeat (8)
      begin
         @(negedge s_6mhz);
         check_idle_outputs();
      end
      reset = 1'b0;
      @(negedge s_6mhz);
      check_idle_outputs();
      // frame 0 has no row for its first group, so it is not checked
      for (int t = 0; t < N_TESTS; t++)
      begin
         wait_vblank();
         write_colors(tests[t].colors);
         mon_active = 1'b1;
         serve_frame(tests[t]);
      end
      wait_vblank();
      mon_active = 1'b0;
      if (exp_q.size() != 0 || vs_checks == 0)
         report_fail("expected pixels were left over or no vsync period was seen");
      else
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

   // pixel monitor, visible cycles pop the model queue
   initial
   begin
      forever
      begin
         @(negedge s_6mhz);
         if (!reset && (sync_o.hblank || sync_o.vblank))
            check_hex("rgb_o", rgb_o, 0);
         else if (mon_active)
         begin
            if (exp_q.size() == 0)
               report_fail("a visible pixel appeared with no expected value");
            else
               check_hex("rgb_o", rgb_o, exp_q.pop_front());
         end
      end
   end

   // frame timing from sync_o, and row requests per line
   initial
   begin
      int   cycle;
      int   hs_last;
      int   vs_last;
      int   hb_run;
      int   req_count;
      int   exp_req;
      int   line_no;
      int   next_line;
      logic hs_seen;
      logic vs_seen;
      logic hb_seen;
      pixel_pkg::sync_t prev;
      cycle = 0;
      hs_last = 0;
      vs_last = 0;
      hb_run = 0;
      req_count = 0;
      vs_checks = 0;
      line_no = 0;
      next_line = 0;
      hs_seen = 1'b0;
      vs_seen = 1'b0;
      hb_seen = 1'b0;
      prev = '0;
      forever
      begin
         @(negedge s_6mhz);
         if (!reset)
         begin
            cycle++;
            if (sync_o.hsync && !prev.hsync)
            begin
               if (hs_seen)
                  check_hex("hsync period", cycle - hs_last, video_timing_pkg::H_TOTAL);
               hs_seen = 1'b1;
               hs_last = cycle;
            end
            if (sync_o.vsync && !prev.vsync)
            begin
               if (vs_seen)
               begin
                  check_hex("vsync period", cycle - vs_last, FRAME_CYCLES);
                  vs_checks++;
               end
               vs_seen = 1'b1;
               vs_last = cycle;
            end
            // hblank fall starts a line, the last line load sits at its end
            if (!sync_o.hblank && prev.hblank)
            begin
               next_line = (line_no + 1) % video_timing_pkg::V_TOTAL;
               check_hex("sync_o.vblank", sync_o.vblank,
                         next_line >= video_timing_pkg::V_VISIBLE);
               if (hb_seen)
               begin
                  exp_req = ((line_no < video_timing_pkg::V_VISIBLE) ? 31 : 0) +
                            ((next_line < video_timing_pkg::V_VISIBLE) ? 1 : 0);
                  check_hex("row_req_o per line", req_count, exp_req);
               end
               hb_seen = 1'b1;
               line_no = next_line;
               req_count = 0;
               hb_run = 0;
            end
            if (sync_o.hblank && !prev.hblank && hb_seen)
               check_hex("hblank low cycles", hb_run, video_timing_pkg::H_VISIBLE);
            if (!sync_o.hblank)
               hb_run++;
            if (row_req_o)
               req_count++;
            prev = sync_o;
         end
      end
   end

   initial
   begin
      timeout_count = 0;
      forever
      begin
         @(posedge s_6mhz);
         timeout_count++;
         if (timeout_count > TIMEOUT_CYCLES)
            report_fail("timeout: the tests did not finish in the allowed number of cycles");
      end
   end

endmodule

//--- tb/centipede_video_chk.sv
/*
 * Concurrent assertions on the top-level ports of centipede_video.
 * Attached with bind, so it needs no change in the design.
 * All properties are sampled on the rising edge of s_6mhz and are
 * off while reset is high.
 */
module centipede_video_chk (
   input  logic             s_6mhz,
   input  logic             reset,
   input  logic             row_req_i,
   input  pixel_pkg::rgb9_t rgb_i,
   input  pixel_pkg::sync_t sync_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // hsync sits inside the horizontal blank window
   hsync_in_hblank: assert property (@(posedge s_6mhz) disable iff (reset)
      sync_i.hsync |-> sync_i.hblank)
      else $error("hsync is high outside hblank");

   // vsync sits inside the vertical blank window
   vsync_in_vblank: assert property (@(posedge s_6mhz) disable iff (reset)
      sync_i.vsync |-> sync_i.vblank)
      else $error("vsync is high outside vblank");

   // no picture while blanked
   black_when_blank: assert property (@(posedge s_6mhz) disable iff (reset)
      (sync_i.hblank || sync_i.vblank) |-> (rgb_i == '0))
      else $error("rgb_o is not black during blanking");

   // row request is a single-cycle strobe
   req_one_cycle: assert property (@(posedge s_6mhz) disable iff (reset)
      row_req_i |=> !row_req_i)
      else $error("row_req_o is high for two cycles in a row");

endmodule

//--- hdl/centipede_video.sv
/*
 * Video output path of the arcade board, on the s_6mhz pixel clock.
 * Tile rows come from outside, one per row_req_o, valid in that cycle.
 * The color index is always PF_COLOR_BASE plus the pixel code.
 * rgb_o and sync_o trail the internal counts by PIPE_DELAY cycles.
 */
module centipede_video (
   input  logic                 s_6mhz,
   input  logic                 reset,
   input  pixel_pkg::color_wr_t color_wr_i,
   input  pixel_pkg::tile_row_t tile_row_i,
   output logic                 row_req_o,
   output pixel_pkg::rgb9_t     rgb_o,
   output pixel_pkg::sync_t     sync_o
);

   pixel_pkg::sync_t     raw_sync;
   logic                 row_load;
   pixel_pkg::pix_code_t pixel;
   pixel_pkg::rgbi_t     color;

   // counters, sync windows and row strobe
   sync_gen u_sync_gen (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .raw_sync_o (raw_sync),
      .row_load_o (row_load)
   );

   // the row strobe doubles as the request to the row source
   assign row_req_o = row_load;

   playfield_shifter u_playfield_shifter (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .row_load_i (row_load),
      .tile_row_i (tile_row_i),
      .pixel_o    (pixel)
   );

   color_ram u_color_ram (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .color_wr_i (color_wr_i),
      .pixel_i    (pixel),
      .color_o    (color)
   );

   video_out u_video_out (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .raw_sync_i (raw_sync),
      .color_i    (color),
      .rgb_o      (rgb_o),
      .sync_o     (sync_o)
   );

endmodule

//--- hdl/video_out.sv
/*
 * Output stage: sync delay line, blanking and palette lookup.
 * raw_sync_i must lead color_i by PIPE_DELAY-1 cycles, as it does
 * from sync_gen through the shifter and the color ram.
 * rgb_o and sync_o are both registered on the same edge.
 */
module video_out (
   input  logic              s_6mhz,
   input  logic              reset,
   input  pixel_pkg::sync_t  raw_sync_i,
   input  pixel_pkg::rgbi_t  color_i,
   output pixel_pkg::rgb9_t  rgb_o,
   output pixel_pkg::sync_t  sync_o
);

   pixel_pkg::sync_t sync_pipe [video_timing_pkg::PIPE_DELAY];
   pixel_pkg::sync_t sync_align;
   pixel_pkg::rgbi_t out_code;

   // sync at the same point as color_i
   assign sync_align = sync_pipe[video_timing_pkg::PIPE_DELAY-2];

   // no picture outside the visible area
   assign out_code = (sync_align.hblank || sync_align.vblank) ?
                     pixel_pkg::BLANK_CODE : color_i;

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < video_timing_pkg::PIPE_DELAY; i++)
         begin
            sync_pipe[i] <= '0;
         end
      end
      else
      begin
         sync_pipe[0] <= raw_sync_i;
         for (int i = 1; i < video_timing_pkg::PIPE_DELAY; i++)
         begin
            sync_pipe[i] <= sync_pipe[i-1];
         end
      end
   end

   // registered color lookup
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         rgb_o <= pixel_pkg::PALETTE[pixel_pkg::BLANK_CODE];
      else
         rgb_o <= pixel_pkg::PALETTE[out_code];
   end

   // last stage of the delay line lines up with rgb_o
   assign sync_o = sync_pipe[video_timing_pkg::PIPE_DELAY-1];

endmodule

//--- playfield/color_ram.sv
/*
 * 16x4 color ram, write port from the processor side.
 * A write on one edge is seen by the pixel read on the next edge.
 * Only entries PF_COLOR_BASE to PF_COLOR_BASE+3 are read here.
 * All entries come out of reset as BLANK_CODE, which is black.
 */
module color_ram (
   input  logic                 s_6mhz,
   input  logic                 reset,
   input  pixel_pkg::color_wr_t color_wr_i,
   input  pixel_pkg::pix_code_t pixel_i,
   output pixel_pkg::rgbi_t     color_o
);

   pixel_pkg::rgbi_t mem [16];
   logic [3:0]       rd_addr;

   // playfield colors sit at base plus the 2-bit code
   assign rd_addr = pixel_pkg::PF_COLOR_BASE + {2'b00, pixel_i};

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < 16; i++)
         begin
            mem[i] <= pixel_pkg::BLANK_CODE;
         end
         color_o <= pixel_pkg::BLANK_CODE;
      end
      else
      begin
         if (color_wr_i.we)
            mem[color_wr_i.addr] <= color_wr_i.data;
         // read before write, same edge returns the old entry
         color_o <= mem[rd_addr];
      end
   end

endmodule

//--- playfield/playfield_shifter.sv
/*
 * Playfield pixel shifter for two bitplanes.
 * The row on tile_row_i must be valid in the cycle row_load_i is high,
 * since there is no hold or back-pressure.
 * Pixel k of a row leaves pixel_o after edge load+1+k.
 * Between rows zeros shift in, which gives pixel code 0.
 */
module playfield_shifter (
   input  logic                 s_6mhz,
   input  logic                 reset,
   input  logic                 row_load_i,
   input  pixel_pkg::tile_row_t tile_row_i,
   output pixel_pkg::pix_code_t pixel_o
);

   logic [video_timing_pkg::ROW_PIXELS-1:0] shift1;
   logic [video_timing_pkg::ROW_PIXELS-1:0] shift0;
   logic [video_timing_pkg::ROW_PIXELS-1:0] plane1_rev;
   logic [video_timing_pkg::ROW_PIXELS-1:0] plane0_rev;

   // bit reversed planes for mirrored tiles
   assign plane1_rev = {<<{tile_row_i.plane1}};
   assign plane0_rev = {<<{tile_row_i.plane0}};

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         shift1  <= '0;
         shift0  <= '0;
         pixel_o <= '0;
      end
      else
      begin
         // msb of both planes is the current pixel
         pixel_o <= {shift1[video_timing_pkg::ROW_PIXELS-1],
                     shift0[video_timing_pkg::ROW_PIXELS-1]};
         if (row_load_i)
         begin
            if (tile_row_i.mirror)
            begin
               shift1 <= plane1_rev;
               shift0 <= plane0_rev;
            end
            else
            begin
               shift1 <= tile_row_i.plane1;
               shift0 <= tile_row_i.plane0;
            end
         end
         else
         begin
            shift1 <= {shift1[video_timing_pkg::ROW_PIXELS-2:0], 1'b0};
            shift0 <= {shift0[video_timing_pkg::ROW_PIXELS-2:0], 1'b0};
         end
      end
   end

endmodule

//--- hdl/sync_gen.sv
/*
 * Sync generator for the video path.
 * raw_sync_o is decoded from the current counts without a register,
 * so it leads the pixels at rgb_o by PIPE_DELAY cycles.
 * row_load_o fires one cycle before each visible group of 8 pixels.
 */
module sync_gen (
   input  logic              s_6mhz,
   input  logic              reset,
   output pixel_pkg::sync_t  raw_sync_o,
   output logic              row_load_o
);

   logic [video_timing_pkg::H_BITS-1:0] h_count;
   logic [video_timing_pkg::V_BITS-1:0] v_count;
   logic [video_timing_pkg::V_BITS-1:0] v_next;
   logic                                h_last;
   logic                                group_end;

   // last pixel clock of the line
   assign h_last = (h_count == video_timing_pkg::H_TOTAL - 1);

   // line number that follows the current one
   assign v_next = (v_count == video_timing_pkg::V_TOTAL - 1) ? '0 : v_count + 1'b1;

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         h_count <= '0;
         v_count <= '0;
      end
      else
      begin
         if (h_last)
         begin
            h_count <= '0;
            // line counter only steps at the end of a line
            v_count <= v_next;
         end
         else
         begin
            h_count <= h_count + 1'b1;
         end
      end
   end

   // sync and blank windows
   always_comb
   begin
      raw_sync_o.hblank = (h_count >= video_timing_pkg::H_VISIBLE);
      raw_sync_o.vblank = (v_count >= video_timing_pkg::V_VISIBLE);
      raw_sync_o.hsync  = (h_count >= video_timing_pkg::H_SYNC_START) &&
                          (h_count < video_timing_pkg::H_SYNC_END);
      raw_sync_o.vsync  = (v_count >= video_timing_pkg::V_SYNC_START) &&
                          (v_count < video_timing_pkg::V_SYNC_END);
   end

   // count 7 of each 8-pixel group
   assign group_end = ((h_count % video_timing_pkg::ROW_PIXELS) ==
                       video_timing_pkg::ROW_PIXELS - 1);

   // load only when the next pixel is visible
   // inside the line this covers counts 7 to 247
   // the last count of the line loads the first group of the next line
   always_comb
   begin
      if (h_last)
         row_load_o = (v_next < video_timing_pkg::V_VISIBLE);
      else
         row_load_o = group_end &&
                      (h_count < video_timing_pkg::H_VISIBLE - 1) &&
                      (v_count < video_timing_pkg::V_VISIBLE);
   end

endmodule

//--- common/pixel_pkg.sv
/*
 * Pixel, tile row, color write and sync types of the video path.
 * Color codes are inverted, as on the board: all ones is black.
 * Playfield pixels always use color entries 4 to 7, since there are
 * no motion objects in this path.
 */
package pixel_pkg;

   // 2-bit code, {plane1, plane0}
   typedef logic [1:0] pix_code_t;

   // inverted color code as stored in the color ram
   typedef logic [3:0] rgbi_t;

   // bbb_ggg_rrr
   typedef logic [8:0] rgb9_t;

   // one 8-pixel row of both bitplanes, msb is the leftmost pixel
   typedef struct packed {
      logic [7:0] plane1;
      logic [7:0] plane0;
      logic       mirror;
   } tile_row_t;

   // processor write into the color ram
   typedef struct packed {
      logic       we;
      logic [3:0] addr;
      rgbi_t      data;
   } color_wr_t;

   typedef struct packed {
      logic hsync;
      logic vsync;
      logic hblank;
      logic vblank;
   } sync_t;

   // rgbi to bbb_ggg_rrr, bit 3 selects the full blue level
   localparam rgb9_t PALETTE [16] = '{
      9'b100_111_111, 9'b100_111_000, 9'b100_000_111, 9'b100_000_000,
      9'b000_100_111, 9'b000_100_000, 9'b000_000_111, 9'b000_000_000,
      9'b111_111_111, 9'b111_111_000, 9'b111_000_111, 9'b111_000_000,
      9'b000_111_111, 9'b000_111_000, 9'b000_000_111, 9'b000_000_000
   };

   // maps to black through PALETTE
   localparam rgbi_t BLANK_CODE = 4'b1111;

   // first color entry of the playfield
   localparam logic [3:0] PF_COLOR_BASE = 4'd4;

endpackage

//--- common/video_timing_pkg.sv
/*
 * Line and frame timing of the video path, all counted in s_6mhz cycles.
 * The visible area starts at count 0 on both axes, and blanking follows it.
 * Sync windows are end exclusive.
 * PIPE_DELAY must match the register stages from row load to rgb_o.
 */
package video_timing_pkg;

   // horizontal, in pixel clocks
   localparam int H_TOTAL = 384;
   localparam int H_VISIBLE = 256;
   // hsync sits in the middle of hblank
   localparam int H_SYNC_START = 288;
   localparam int H_SYNC_END = 320;

   // vertical, in lines
   localparam int V_TOTAL = 256;
   localparam int V_VISIBLE = 240;
   localparam int V_SYNC_START = 244;
   localparam int V_SYNC_END = 248;

   // one tile row is 8 pixels, so a row is requested every 8 clocks
   localparam int ROW_PIXELS = 8;

   // shifter, color ram read and output register
   localparam int PIPE_DELAY = 3;

   // counter widths, wide enough for H_TOTAL-1 and V_TOTAL-1
   localparam int H_BITS = 9;
   localparam int V_BITS = 8;

endpackage
